//--- vector_controller.f
foc_data_pkg.sv
foc_ctrl_pkg.sv
clarke_transform.sv
park_transform.sv
pi_controller.sv
space_vector_modulator.sv
vector_controller.sv
vector_controller_sva.sv
tb_vector_controller.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_vector_controller
FILELIST  ?= vector_controller.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUNFLAGS  ?= +verilator+error+limit+1000
FAIL_MSG  := SOME TESTS FAILED
PASS_MSG  := ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_vector_controller.sv
// runs the loop at theta 0 and 128 only; expected values come from a local fixed-point model
`timescale 1ns/10ps
`default_nettype none

module tb_vector_controller;

    localparam int DATA_LIMIT = 2960;
    localparam int PWM_PERIOD = 3000;
    localparam int OUT_MIN = 20;
    localparam int OUT_MAX = 2980;
    localparam int SETTLE = 12;      // lets a stale inverse pass drain
    localparam int WAIT_LIMIT = 40;  // cycles before a handshake wait gives up
    localparam int STEP_CYCLES = 2 * (SETTLE + WAIT_LIMIT) + 8; // worst loop step
    localparam int MAX_STEPS = 40;
    localparam int WATCHDOG_NS = (MAX_STEPS * STEP_CYCLES + 100) * 4;

    logic clk, reset;
    foc_data_pkg::uv_pair current_uv;
    logic current_uv_valid;
    logic [8:0] theta;
    foc_data_pkg::dq_pair current_reference;
    logic current_reference_valid, control_tick, fault, brake;
    logic signed [15:0] param_kp, param_ki;
    foc_data_pkg::dq_pair current_measurement;
    logic current_measurement_valid;
    foc_data_pkg::uvw_duty driver_pwm;
    logic driver_pwm_valid;

    int seed = 56718;
    int errors = 0;
    int tests_failed = 0;
    int test_start = 0;

    vector_controller #(
        .THETA_WIDTH(9), .GAIN_SCALE(14), .DATA_LIMIT(DATA_LIMIT),
        .PWM_PERIOD(PWM_PERIOD), .OUT_MIN(OUT_MIN), .OUT_MAX(OUT_MAX)
    ) uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run is stuck", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    function automatic int clarke_beta(input int u, input int v);
        return ((u + 2 * v) * foc_ctrl_pkg::inv_sqrt3_q15) >>> 15;
    endfunction

    // first PI step from a zero integrator, saturated to the command range
    function automatic int pi_command(input int error, input int kp, input int ki);
        longint total;
        total = ((longint'(kp) + longint'(ki)) * error) >>> 14;
        if (total > DATA_LIMIT) return DATA_LIMIT;
        if (total < -DATA_LIMIT) return -DATA_LIMIT;
        return int'(total);
    endfunction

    task automatic check_equal(input string what, input int actual, input int expected);
        assert (actual == expected) else begin
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic check_duties(input int alpha, input int beta, input foc_data_pkg::uvw_duty d);
        int ph [3];
        int got [3];
        int t, hi, lo, offset, e;
        t = (beta * foc_ctrl_pkg::sqrt3_q14) >>> 14;
        ph[0] = alpha; // inverse Clarke
        ph[1] = (t - alpha) >>> 1;
        ph[2] = (-alpha - t) >>> 1;
        got[0] = d.u;
        got[1] = d.v;
        got[2] = d.w;
        hi = ph[0];
        lo = ph[0];
        for (int i = 1; i < 3; i++) begin
            if (ph[i] > hi) hi = ph[i];
            if (ph[i] < lo) lo = ph[i];
        end
        offset = (hi + lo) >>> 1;
        for (int i = 0; i < 3; i++) begin
            e = ph[i] - offset + PWM_PERIOD / 2;
            if (e < OUT_MIN) e = OUT_MIN;
            else if (e > OUT_MAX) e = OUT_MAX;
            check_equal($sformatf("duty of phase %0d", i), got[i], e);
        end
    endtask

    // unclamped min-max output is centered on the half period
    task automatic check_centered(input foc_data_pkg::uvw_duty d);
        int hi, lo;
        hi = (d.u > d.v) ? d.u : d.v;
        hi = (d.w > hi) ? d.w : hi;
        lo = (d.u < d.v) ? d.u : d.v;
        lo = (d.w < lo) ? d.w : lo;
        if (lo > OUT_MIN && hi < OUT_MAX) begin
            assert (hi + lo - PWM_PERIOD <= 1 && PWM_PERIOD - hi - lo <= 1) else begin
                $display("Error at %0t ns: max %0d plus min %0d is off center", $time, hi, lo);
                errors++;
            end
        end
    endtask

    task automatic send_sample(input int u, input int v, input int angle);
        @(posedge clk);
        current_uv.u <= 16'(u);
        current_uv.v <= 16'(v);
        theta <= 9'(angle);
        current_uv_valid <= 1'b1;
        @(posedge clk);
        current_uv_valid <= 1'b0;
    endtask

    task automatic wait_measurement(output foc_data_pkg::dq_pair m);
        int n;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(negedge clk);
            if (current_measurement_valid) break;
        end
        m = current_measurement;
        assert (n < WAIT_LIMIT) else begin
            $display("no current_measurement_valid within %0d cycles", WAIT_LIMIT);
            errors++;
        end
    endtask

    task automatic wait_pwm(output foc_data_pkg::uvw_duty d);
        int n;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(negedge clk);
            if (driver_pwm_valid) break;
        end
        d = driver_pwm;
        assert (n < WAIT_LIMIT) else begin
            $display("no driver_pwm_valid within %0d cycles", WAIT_LIMIT);
            errors++;
        end
    endtask

    task automatic pulse_fault();
        @(posedge clk);
        fault <= 1'b1;
        repeat (2) @(posedge clk);
        fault <= 1'b0;
    endtask

    // reference, measurement, tick, then a second sample that releases the command
    task automatic run_loop(input int ref_d, input int ref_q, input int u, input int v,
                            output foc_data_pkg::uvw_duty d);
        foc_data_pkg::dq_pair m;
        @(posedge clk);
        current_reference.d <= 16'(ref_d);
        current_reference.q <= 16'(ref_q);
        current_reference_valid <= 1'b1;
        @(posedge clk);
        current_reference_valid <= 1'b0;
        send_sample(u, v, 0);
        wait_measurement(m);
        repeat (SETTLE) @(posedge clk);
        control_tick <= 1'b1;
        @(posedge clk);
        control_tick <= 1'b0;
        repeat (4) @(posedge clk); // PI result after 3 cycles
        send_sample(u, v, 0);
        wait_pwm(d);
    endtask

    task automatic end_test(input int number, input string name);
        if (errors == test_start) begin
            $display("test %0d %s: pass", number, name);
        end else begin
            $display("test %0d %s: fail with %0d errors", number, name, errors - test_start);
            tests_failed++;
        end
        test_start = errors;
    endtask

    initial begin
        foc_data_pkg::dq_pair meas;
        foc_data_pkg::uvw_duty duty;
        int u, v, a, b, cb, angle;
        reset = 1'b1;
        current_uv = '0;
        current_uv_valid = 1'b0;
        theta = '0;
        current_reference = '0;
        current_reference_valid = 1'b0;
        control_tick = 1'b0;
        param_kp = 16'sd16384; // unity gain in Q14
        param_ki = '0;
        fault = 1'b0;
        brake = 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < 16; i++) begin
            u = $random(seed) % 8000;
            v = $random(seed) % 8000;
            angle = (i < 8) ? 0 : 128;
            send_sample(u, v, angle);
            wait_measurement(meas);
            cb = clarke_beta(u, v);
            check_equal("measured d", meas.d, (angle == 0) ? u : cb);
            check_equal("measured q", meas.q, (angle == 0) ? cb : -u);
        end
        end_test(1, "forward path");

        for (int i = 0; i < 6; i++) begin
            a = $random(seed) % 1200;
            b = $random(seed) % 1200;
            u = $random(seed) % 600;
            v = $random(seed) % 600;
            run_loop(a, b, u, v, duty);
            check_duties(pi_command(a - u, 16384, 0), pi_command(b - clarke_beta(u, v), 16384, 0),
                         duty);
        end
        end_test(2, "proportional loop");

        run_loop(10000, -10000, 0, 0, duty);
        check_duties(DATA_LIMIT, -DATA_LIMIT, duty);
        run_loop(-10000, 10000, 0, 0, duty);
        check_duties(-DATA_LIMIT, DATA_LIMIT, duty);
        end_test(3, "saturation");

        @(posedge clk);
        brake <= 1'b1;
        run_loop(1000, 500, 0, 0, duty);
        @(posedge clk);
        brake <= 1'b0;
        check_duties(0, 0, duty); // zero command puts every phase at half period
        end_test(4, "brake");

        param_kp <= '0;
        param_ki <= 16'sd4096;
        run_loop(800, -1200, 0, 0, duty); // leaves one step in each integrator
        check_duties(pi_command(800, 0, 4096), pi_command(-1200, 0, 4096), duty);
        pulse_fault();
        send_sample(0, 0, 0);
        wait_measurement(meas);
        repeat (16) begin
            @(negedge clk);
            assert (!driver_pwm_valid) else begin
                $display("driver_pwm_valid came before any PI result after fault");
                errors++;
            end
        end
        run_loop(800, -1200, 0, 0, duty);
        check_duties(pi_command(800, 0, 4096), pi_command(-1200, 0, 4096), duty);
        end_test(5, "fault");

        pulse_fault(); // clears the integrator left by the fault test
        param_kp <= 16'sd16384;
        param_ki <= '0;
        for (int i = 0; i < 8; i++) begin
            a = $random(seed) % 1500;
            b = $random(seed) % 1500;
            run_loop(a, b, 0, 0, duty);
            check_duties(a, b, duty);
            check_centered(duty);
        end
        end_test(6, "random inverse path");

        $display("tests run 6, tests failed %0d, check errors %0d, assertion failures %0d",
                 tests_failed, errors, uut.sva.fail_count);
        if (tests_failed == 0 && uut.sva.fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vector_controller_sva.sv
// latency checks expect control_tick only while the PI is idle; fault aborts them
`timescale 1ns/10ps
`default_nettype none

module vector_controller_sva #(
    parameter int PWM_PERIOD = 3000,
    parameter int OUT_MIN = 20,
    parameter int OUT_MAX = 2980
) (
    input wire                        clk,
    input wire                        reset,
    input wire                        fault,
    input wire                        current_uv_valid,
    input wire                        current_measurement_valid,
    input wire                        control_tick,
    input wire                        pi_valid,
    input wire foc_data_pkg::uvw_duty driver_pwm,
    input wire                        driver_pwm_valid
);

    localparam logic [11:0] HALF_PERIOD = 12'(PWM_PERIOD / 2);

    int fail_count = 0; // read by the testbench

    meas_latency: assert property (
        @(posedge clk) disable iff (reset || fault)
        current_uv_valid |-> ##4 current_measurement_valid
    ) else begin
        $error("measurement did not follow the current sample after 4 cycles");
        fail_count++;
    end

    pi_latency: assert property (
        @(posedge clk) disable iff (reset || fault)
        control_tick |-> ##3 pi_valid
    ) else begin
        $error("PI result did not follow control_tick after 3 cycles");
        fail_count++;
    end

    duty_range: assert property (
        @(posedge clk) disable iff (reset)
        driver_pwm_valid |-> driver_pwm.u >= 12'(OUT_MIN) && driver_pwm.u <= 12'(OUT_MAX)
            && driver_pwm.v >= 12'(OUT_MIN) && driver_pwm.v <= 12'(OUT_MAX)
            && driver_pwm.w >= 12'(OUT_MIN) && driver_pwm.w <= 12'(OUT_MAX)
    ) else begin
        $error("duty outside the allowed range");
        fail_count++;
    end

    // second reset cycle onward, so the first edge is not judged
    reset_state: assert property (
        @(posedge clk)
        reset && $past(reset) |-> !current_measurement_valid && !driver_pwm_valid
            && driver_pwm.u == HALF_PERIOD && driver_pwm.v == HALF_PERIOD
            && driver_pwm.w == HALF_PERIOD
    ) else begin
        $error("outputs not in their idle state during reset");
        fail_count++;
    end

endmodule

bind vector_controller vector_controller_sva #(
    .PWM_PERIOD(PWM_PERIOD), .OUT_MIN(OUT_MIN), .OUT_MAX(OUT_MAX)
) sva (
    .clk(clk), .reset(reset), .fault(fault),
    .current_uv_valid(current_uv_valid),
    .current_measurement_valid(current_measurement_valid),
    .control_tick(control_tick), .pi_valid(pi_valid),
    .driver_pwm(driver_pwm), .driver_pwm_valid(driver_pwm_valid)
);

`default_nettype wire

//--- vector_controller.sv
// rotor angle is a plain input latched with each current sample; fault clears all but Clarke
`timescale 1ns/10ps
`default_nettype none

module vector_controller #(
    parameter int THETA_WIDTH = 9,
    parameter int GAIN_SCALE = 14,
    parameter int DATA_LIMIT = 2960,
    parameter int PWM_PERIOD = 3000,
    parameter int OUT_MIN = 20,
    parameter int OUT_MAX = 2980
) (
    input  wire                   clk,
    input  wire                   reset,
    input  wire foc_data_pkg::uv_pair current_uv,
    input  wire                   current_uv_valid,
    input  wire [THETA_WIDTH-1:0] theta,
    input  wire foc_data_pkg::dq_pair current_reference,
    input  wire                   current_reference_valid,
    input  wire                   control_tick,
    input  wire signed [15:0]     param_kp,
    input  wire signed [15:0]     param_ki,
    input  wire                   fault,
    input  wire                   brake,
    output foc_data_pkg::dq_pair  current_measurement,
    output logic                  current_measurement_valid,
    output foc_data_pkg::uvw_duty driver_pwm,
    output logic                  driver_pwm_valid
);

    logic pipe_reset;
    logic [THETA_WIDTH-1:0] theta_q;
    foc_data_pkg::ab_pair current_ab;
    logic current_ab_valid, current_ab_ready;
    foc_data_pkg::dq_pair pi_data, cmd_data;
    logic pi_valid;
    logic cmd_available; // a command has been computed since reset or fault
    logic cmd_request, cmd_ready;
    foc_data_pkg::ab_pair volt_ab;
    logic volt_valid, volt_ready;

    assign pipe_reset = reset | fault;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) theta_q <= '0;
        else if (current_uv_valid) theta_q <= theta; // same angle for both directions
    end

    // voltage command, resent to the inverse Park after each measurement
    always_ff @(posedge clk, posedge pipe_reset) begin
        if (pipe_reset) begin
            cmd_data <= '0;
            cmd_available <= 1'b0;
            cmd_request <= 1'b0;
        end else begin
            if (pi_valid) begin
                cmd_data <= pi_data;
                cmd_available <= 1'b1;
            end
            if (cmd_available & current_measurement_valid) cmd_request <= 1'b1;
            else if (cmd_request & cmd_ready) cmd_request <= 1'b0;
        end
    end

    clarke_transform clarke (
        .clk(clk), .reset(reset),
        .in_data(current_uv), .in_valid(current_uv_valid), .in_ready(),
        .out_data(current_ab), .out_valid(current_ab_valid), .out_ready(current_ab_ready)
    );

    park_transform #(.THETA_WIDTH(THETA_WIDTH)) park (
        .clk(clk), .reset(pipe_reset),
        .fwd_data(current_ab), .fwd_valid(current_ab_valid), .fwd_ready(current_ab_ready),
        .inv_data(cmd_data), .inv_valid(cmd_request), .inv_ready(cmd_ready),
        .theta(theta_q),
        .meas_data(current_measurement), .meas_valid(current_measurement_valid),
        .volt_data(volt_ab), .volt_valid(volt_valid), .volt_ready(volt_ready)
    );

    pi_controller #(.GAIN_SCALE(GAIN_SCALE), .DATA_LIMIT(DATA_LIMIT)) pi (
        .clk(clk), .reset(reset), .fault(fault), .brake(brake), .trigger(control_tick),
        .kp(param_kp), .ki(param_ki),
        .ref_data(current_reference), .ref_valid(current_reference_valid),
        .meas_data(current_measurement), .meas_valid(current_measurement_valid),
        .out_data(pi_data), .out_valid(pi_valid)
    );

    space_vector_modulator #(
        .PWM_PERIOD(PWM_PERIOD), .OUT_MIN(OUT_MIN), .OUT_MAX(OUT_MAX)
    ) svm (
        .clk(clk), .reset(pipe_reset),
        .in_data(volt_ab), .in_valid(volt_valid), .in_ready(volt_ready),
        .out_data(driver_pwm), .out_valid(driver_pwm_valid)
    );

endmodule

`default_nettype wire

//--- space_vector_modulator.sv
// two-stage pass with no back-pressure; duties are clamped to OUT_MIN..OUT_MAX
`timescale 1ns/10ps
`default_nettype none

module space_vector_modulator #(
    parameter int PWM_PERIOD = 3000,
    parameter int OUT_MIN = 20,
    parameter int OUT_MAX = 2980
) (
    input  wire                   clk,
    input  wire                   reset,
    input  wire foc_data_pkg::ab_pair in_data,
    input  wire                   in_valid,
    output logic                  in_ready,
    output foc_data_pkg::uvw_duty out_data,
    output logic                  out_valid
);

    localparam int HALF_PERIOD = PWM_PERIOD / 2;

    logic signed [31:0] beta_scaled;
    logic signed [17:0] beta_term; // sqrt3 * beta
    logic s1_valid;
    logic signed [17:0] s1_ph [3]; // u, v, w
    logic signed [17:0] ph_max, ph_min;
    logic signed [19:0] offset;
    logic signed [19:0] duty [3];

    assign in_ready = 1'b1;
    assign beta_scaled = in_data.beta * 16'(foc_ctrl_pkg::sqrt3_q14);
    assign beta_term = 18'(beta_scaled >>> 14);

    always_comb begin
        ph_max = s1_ph[0];
        ph_min = s1_ph[0];
        for (int i = 1; i < 3; i++) begin
            if (s1_ph[i] > ph_max) ph_max = s1_ph[i];
            if (s1_ph[i] < ph_min) ph_min = s1_ph[i];
        end
        offset = (20'(ph_max) + 20'(ph_min)) >>> 1; // min-max common mode
        for (int i = 0; i < 3; i++) begin
            duty[i] = 20'(s1_ph[i]) - offset + 20'(HALF_PERIOD);
            if (duty[i] < 20'(OUT_MIN)) duty[i] = 20'(OUT_MIN);
            else if (duty[i] > 20'(OUT_MAX)) duty[i] = 20'(OUT_MAX);
        end
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            s1_valid <= 1'b0;
            out_valid <= 1'b0;
            out_data.u <= 12'(HALF_PERIOD); // idle at 50 percent
            out_data.v <= 12'(HALF_PERIOD);
            out_data.w <= 12'(HALF_PERIOD);
        end else begin
            s1_valid <= in_valid;
            out_valid <= s1_valid;
            if (s1_valid) begin
                out_data.u <= 12'(duty[0]);
                out_data.v <= 12'(duty[1]);
                out_data.w <= 12'(duty[2]);
            end
        end
    end

    // inverse Clarke
    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_ph[0] <= 18'(in_data.alpha);
            s1_ph[1] <= (beta_term - 18'(in_data.alpha)) >>> 1;
            s1_ph[2] <= (-18'(in_data.alpha) - beta_term) >>> 1;
        end
    end

endmodule

`default_nettype wire

//--- pi_controller.sv
// triggers arriving while a step is in progress are ignored; gains are signed Q(GAIN_SCALE)
`timescale 1ns/10ps
`default_nettype none

module pi_controller #(
    parameter int GAIN_SCALE = 14,
    parameter int DATA_LIMIT = 2960
) (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   fault,
    input  wire                   brake,
    input  wire                   trigger,
    input  wire signed [15:0]     kp,
    input  wire signed [15:0]     ki,
    input  wire foc_data_pkg::dq_pair ref_data,
    input  wire                   ref_valid,
    input  wire foc_data_pkg::dq_pair meas_data,
    input  wire                   meas_valid,
    output foc_data_pkg::dq_pair  out_data,
    output logic                  out_valid
);

    localparam logic signed [39:0] INTEG_LIMIT = 40'(DATA_LIMIT) <<< GAIN_SCALE;

    foc_ctrl_pkg::pi_state_e state;
    logic signed [15:0] ref_v [2]; // index 0 is d, 1 is q
    logic signed [15:0] meas_v [2];
    logic signed [16:0] err [2];
    logic signed [32:0] prop [2];
    logic signed [32:0] step [2];
    logic signed [39:0] integ [2];
    logic signed [39:0] integ_next [2];
    logic signed [40:0] scaled [2];

    function automatic logic signed [15:0] saturate(input logic signed [40:0] value);
        if (value > 41'(DATA_LIMIT)) return 16'(DATA_LIMIT);
        if (value < -41'(DATA_LIMIT)) return -16'(DATA_LIMIT);
        return 16'(value);
    endfunction

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            integ_next[i] = integ[i] + 40'(step[i]);
            if (integ_next[i] > INTEG_LIMIT) integ_next[i] = INTEG_LIMIT; // anti-windup
            else if (integ_next[i] < -INTEG_LIMIT) integ_next[i] = -INTEG_LIMIT;
            scaled[i] = (41'(prop[i]) + 41'(integ_next[i])) >>> GAIN_SCALE;
        end
    end

    assign out_valid = (state == foc_ctrl_pkg::pi_sum);

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state <= foc_ctrl_pkg::pi_idle;
            ref_v <= '{default: '0};
            meas_v <= '{default: '0};
            integ <= '{default: '0};
            out_data <= '0;
        end else begin
            if (ref_valid) ref_v <= '{ref_data.d, ref_data.q};
            if (meas_valid) meas_v <= '{meas_data.d, meas_data.q};
            if (fault) begin
                state <= foc_ctrl_pkg::pi_idle;
                integ <= '{default: '0};
            end else begin
                case (state)
                    foc_ctrl_pkg::pi_idle: if (trigger) state <= foc_ctrl_pkg::pi_error;
                    foc_ctrl_pkg::pi_error: state <= foc_ctrl_pkg::pi_multiply;
                    foc_ctrl_pkg::pi_multiply: begin
                        state <= foc_ctrl_pkg::pi_sum;
                        for (int i = 0; i < 2; i++) integ[i] <= brake ? '0 : integ_next[i];
                        out_data.d <= brake ? '0 : saturate(scaled[0]);
                        out_data.q <= brake ? '0 : saturate(scaled[1]);
                    end
                    default: state <= foc_ctrl_pkg::pi_idle; // result shown for one cycle
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (state == foc_ctrl_pkg::pi_idle && trigger) err[i] <= ref_v[i] - meas_v[i];
            if (state == foc_ctrl_pkg::pi_error) begin
                prop[i] <= kp * err[i];
                step[i] <= ki * err[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- park_transform.sv
// three-stage shared Park engine; forward requests win, theta is sampled with the request
`timescale 1ns/10ps
`default_nettype none

module park_transform #(
    parameter int THETA_WIDTH = 9
) (
    input  wire                   clk,
    input  wire                   reset,
    input  wire foc_data_pkg::ab_pair fwd_data,
    input  wire                   fwd_valid,
    output logic                  fwd_ready,
    input  wire foc_data_pkg::dq_pair inv_data,
    input  wire                   inv_valid,
    output logic                  inv_ready,
    input  wire [THETA_WIDTH-1:0] theta,
    output foc_data_pkg::dq_pair  meas_data,
    output logic                  meas_valid,
    output foc_data_pkg::ab_pair  volt_data,
    output logic                  volt_valid,
    input  wire                   volt_ready
);

    localparam foc_ctrl_pkg::cos_table_t COS_LUT = foc_ctrl_pkg::cos_table();
    localparam int QUARTER = 1 << (THETA_WIDTH - 2); // 90 degrees

    logic pipe_en;
    foc_ctrl_pkg::park_dir_e mux_dir;
    logic signed [15:0] mux_x, mux_y;
    logic [THETA_WIDTH-1:0] sin_index;
    logic s1_valid, s2_valid, s3_valid;
    foc_ctrl_pkg::park_dir_e s1_dir, s2_dir, s3_dir;
    logic signed [15:0] s1_x, s1_y, s1_cos, s1_sin;
    logic signed [31:0] s2_xc, s2_xs, s2_yc, s2_ys;
    logic signed [32:0] sum1, sum2;
    logic signed [15:0] s3_r1, s3_r2;

    // only a held inverse result can stall, measurements are always taken
    assign pipe_en = ~(s3_valid & (s3_dir == foc_ctrl_pkg::inverse_park) & ~volt_ready);
    assign fwd_ready = pipe_en;
    assign inv_ready = pipe_en & ~fwd_valid;

    assign mux_dir = fwd_valid ? foc_ctrl_pkg::forward_park : foc_ctrl_pkg::inverse_park;
    assign mux_x = fwd_valid ? fwd_data.alpha : inv_data.d;
    assign mux_y = fwd_valid ? fwd_data.beta : inv_data.q;
    assign sin_index = theta - THETA_WIDTH'(QUARTER); // sin(t) = cos(t - 90)

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
            s1_dir <= foc_ctrl_pkg::forward_park;
            s2_dir <= foc_ctrl_pkg::forward_park;
            s3_dir <= foc_ctrl_pkg::forward_park;
        end else if (pipe_en) begin
            s1_valid <= fwd_valid | inv_valid;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
            s1_dir <= mux_dir;
            s2_dir <= s1_dir;
            s3_dir <= s2_dir;
        end
    end

    // flipping the sine turns the forward rotation into the inverse one
    assign sum1 = s2_xc + s2_ys;
    assign sum2 = s2_yc - s2_xs;

    always_ff @(posedge clk) begin
        if (pipe_en) begin
            s1_x <= mux_x; // stage 1, table lookup
            s1_y <= mux_y;
            s1_cos <= COS_LUT[theta];
            s1_sin <= (mux_dir == foc_ctrl_pkg::forward_park) ? COS_LUT[sin_index]
                                                              : -COS_LUT[sin_index];
            s2_xc <= s1_x * s1_cos; // stage 2, products
            s2_xs <= s1_x * s1_sin;
            s2_yc <= s1_y * s1_cos;
            s2_ys <= s1_y * s1_sin;
            s3_r1 <= 16'(sum1 >>> 14); // stage 3, back from Q14
            s3_r2 <= 16'(sum2 >>> 14);
        end
    end

    // tag steers the result
    assign meas_data.d = s3_r1;
    assign meas_data.q = s3_r2;
    assign meas_valid = s3_valid & (s3_dir == foc_ctrl_pkg::forward_park);
    assign volt_data.alpha = s3_r1;
    assign volt_data.beta = s3_r2;
    assign volt_valid = s3_valid & (s3_dir == foc_ctrl_pkg::inverse_park);

endmodule

`default_nettype wire

//--- clarke_transform.sv
// one register stage; w is not sampled, balanced phase currents are assumed
`timescale 1ns/10ps
`default_nettype none

module clarke_transform (
    input  wire                  clk,
    input  wire                  reset,
    input  wire foc_data_pkg::uv_pair in_data,
    input  wire                  in_valid,
    output logic                 in_ready,
    output foc_data_pkg::ab_pair out_data,
    output logic                 out_valid,
    input  wire                  out_ready
);

    logic signed [17:0] u_plus_2v;
    logic signed [34:0] beta_scaled;

    assign in_ready = ~out_valid | out_ready; // stall only while the result is held
    assign u_plus_2v = 18'(in_data.u) + (18'(in_data.v) <<< 1);
    assign beta_scaled = u_plus_2v * 17'(foc_ctrl_pkg::inv_sqrt3_q15);

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid & in_ready) begin
            out_data.alpha <= in_data.u;
            out_data.beta <= 16'(beta_scaled >>> 15); // back from Q15
        end
    end

endmodule

`default_nettype wire

//--- foc_ctrl_pkg.sv
// cosine table is 512 entries in Q14, so the rotor angle must be 9 bits wide
`default_nettype none

package foc_ctrl_pkg;

    typedef enum logic {forward_park, inverse_park} park_dir_e;

    typedef enum logic [1:0] {pi_idle, pi_error, pi_multiply, pi_sum} pi_state_e;

    localparam int COS_ENTRIES = 512;
    localparam int COS_ONE = 16384;        // unity in Q14
    localparam int inv_sqrt3_q15 = 18919;  // 1/sqrt(3) in Q15
    localparam int sqrt3_q14 = 28378;      // sqrt(3) in Q14

    typedef logic signed [15:0] cos_table_t [COS_ENTRIES];

    function automatic cos_table_t cos_table();
        cos_table_t table_out;
        real value;
        for (int i = 0; i < COS_ENTRIES; i++) begin
            value = COS_ONE * $cos(2.0 * 3.141592653589793 * i / COS_ENTRIES);
            // round half away from zero, keeps quarter points exact
            table_out[i] = 16'($rtoi(value < 0.0 ? value - 0.5 : value + 0.5));
        end
        return table_out;
    endfunction

endpackage

`default_nettype wire

//--- foc_data_pkg.sv
// widths are fixed at 16-bit signed values and 12-bit duties; top-level widths must match these
`default_nettype none

package foc_data_pkg;

    localparam int CURRENT_WIDTH = 16; // signed currents and voltages
    localparam int DRIVER_WIDTH = 12;  // unsigned duty counts

    // stationary frame
    typedef struct packed {
        logic signed [CURRENT_WIDTH-1:0] alpha;
        logic signed [CURRENT_WIDTH-1:0] beta;
    } ab_pair;

    // rotor frame
    typedef struct packed {
        logic signed [CURRENT_WIDTH-1:0] d;
        logic signed [CURRENT_WIDTH-1:0] q;
    } dq_pair;

    typedef struct packed {
        logic signed [CURRENT_WIDTH-1:0] u; // w is implied by u + v + w = 0
        logic signed [CURRENT_WIDTH-1:0] v;
    } uv_pair;

    typedef struct packed {
        logic [DRIVER_WIDTH-1:0] u;
        logic [DRIVER_WIDTH-1:0] v;
        logic [DRIVER_WIDTH-1:0] w;
    } uvw_duty;

endpackage

`default_nettype wire
